/* rtl/irq_pkg.sv */
package irq_pkg;

  localparam int IRQ_VEC_W = 15;

  // Four clk_en ticks per 256 Hz step keep simulation short
  localparam int TIMEBASE_DIV   = 4;
  localparam int TIMEBASE_DIV_W = $clog2(TIMEBASE_DIV);

  // Step count taps for the square waves
  localparam int HZ32_BIT = 2;
  localparam int HZ8_BIT  = 4;
  localparam int HZ2_BIT  = 6;
  localparam int HZ1_BIT  = 7;

  typedef logic [7:0]           axil_addr_t;
  typedef logic [31:0]          axil_data_t;
  typedef logic [IRQ_VEC_W-1:0] irq_vec_t;
  typedef logic [3:0]           irq_index_t;
  typedef logic [7:0]           step_count_t;

  typedef struct packed {
    logic hz32;
    logic hz8;
    logic hz2;
    logic hz1;
  } timer_levels_t;

  typedef struct packed {
    logic [3:0] clock;
    logic [1:0] stopwatch;
    logic       prog_timer;
    logic [1:0] input_k;
  } factor_set_t;

  // Masks share the factor layout
  typedef factor_set_t mask_set_t;

  typedef struct packed {
    logic clock;
    logic stopwatch;
    logic prog_timer;
    logic input_k;
  } factor_clear_t;

  // Request vector slots
  localparam irq_index_t SLOT_CLOCK      = 4'd1;
  localparam irq_index_t SLOT_STOPWATCH  = 4'd3;
  localparam irq_index_t SLOT_K0         = 4'd5;
  localparam irq_index_t SLOT_K1         = 4'd7;
  localparam irq_index_t SLOT_PROG_TIMER = 4'd11;

  // Register byte offsets
  localparam axil_addr_t REG_CLOCK_MASK       = 8'h00;
  localparam axil_addr_t REG_STOPWATCH_MASK   = 8'h04;
  localparam axil_addr_t REG_PROG_MASK        = 8'h08;
  localparam axil_addr_t REG_INPUT_MASK       = 8'h0C;
  localparam axil_addr_t REG_CLOCK_FACTOR     = 8'h10;
  localparam axil_addr_t REG_STOPWATCH_FACTOR = 8'h14;
  localparam axil_addr_t REG_PROG_FACTOR      = 8'h18;
  localparam axil_addr_t REG_INPUT_FACTOR     = 8'h1C;
  localparam axil_addr_t REG_STEP_COUNT       = 8'h20;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* rtl/clock_timebase.sv */
`timescale 1ns/1ps

module clock_timebase (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   clk_en,
  output irq_pkg::timer_levels_t levels,
  output irq_pkg::step_count_t   step_count
);
  import irq_pkg::*;

  logic [TIMEBASE_DIV_W-1:0] div_count;
  logic                      div_wrap;

  // Last clk_en tick of the current 256 Hz step
  assign div_wrap = (div_count == TIMEBASE_DIV_W'(TIMEBASE_DIV - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      div_count  <= '0;
      step_count <= '0;
    end else if (clk_en) begin
      if (div_wrap) begin
        div_count  <= '0;
        step_count <= step_count + 1'b1;
      end else begin
        div_count <= div_count + 1'b1;
      end
    end
  end

  // Each level is a binary tap of the step count
  // so 32 Hz has a period of 8 steps
  assign levels = '{
    hz32: step_count[HZ32_BIT],
    hz8:  step_count[HZ8_BIT],
    hz2:  step_count[HZ2_BIT],
    hz1:  step_count[HZ1_BIT]
  };

  // Timebase only moves on enabled cycles
  a_step_hold: assert property (
    @(posedge clk) disable iff (reset)
    !clk_en |=> $stable(step_count)
  );

endmodule

/* rtl/clock_factor_latch.sv */
`timescale 1ns/1ps

module clock_factor_latch (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   clk_en,
  input  irq_pkg::timer_levels_t levels,
  input  logic                   clear,
  output logic [3:0]             clock_factor
);

  logic prev_hz32;
  logic prev_hz8;
  logic prev_hz2;
  logic prev_hz1;
  logic [3:0] falling;

  // Factor bit order follows the vector slot with 32 Hz in bit 0
  assign falling[0] = prev_hz32 & ~levels.hz32;
  assign falling[1] = prev_hz8 & ~levels.hz8;
  assign falling[2] = prev_hz2 & ~levels.hz2;
  assign falling[3] = prev_hz1 & ~levels.hz1;

  always_ff @(posedge clk) begin
    if (reset) begin
      prev_hz32    <= 1'b0;
      prev_hz8     <= 1'b0;
      prev_hz2     <= 1'b0;
      prev_hz1     <= 1'b0;
      clock_factor <= '0;
    end else begin
      if (clk_en) begin
        prev_hz32 <= levels.hz32;
        prev_hz8  <= levels.hz8;
        prev_hz2  <= levels.hz2;
        prev_hz1  <= levels.hz1;

        // Sticky until the CPU reads the factor register
        clock_factor <= clock_factor | falling;
      end

      // Read clear acts without clk_en and beats a set
      if (clear) begin
        clock_factor <= '0;
      end
    end
  end

endmodule

/* rtl/peripheral_factor_latch.sv */
`timescale 1ns/1ps

module peripheral_factor_latch (
  input  logic       clk,
  input  logic       reset,
  input  logic       clk_en,
  input  logic [1:0] stopwatch_event,
  input  logic       prog_timer_event,
  input  logic [1:0] k_pins,
  input  logic [1:0] input_mask,
  input  logic       stopwatch_clear,
  input  logic       prog_clear,
  input  logic       input_clear,
  output logic [1:0] stopwatch_factor,
  output logic       prog_timer_factor,
  output logic [1:0] input_factor
);

  logic [1:0] prev_k;
  logic [1:0] k_fall;

  // The input mask gates the set here, not the request
  assign k_fall = prev_k & ~k_pins & input_mask;

  always_ff @(posedge clk) begin
    if (reset) begin
      prev_k            <= '0;
      stopwatch_factor  <= '0;
      prog_timer_factor <= 1'b0;
      input_factor      <= '0;
    end else begin
      if (clk_en) begin
        prev_k            <= k_pins;
        stopwatch_factor  <= stopwatch_factor | stopwatch_event;
        prog_timer_factor <= prog_timer_factor | prog_timer_event;
        input_factor      <= input_factor | k_fall;
      end

      // Each group clear wins over a set
      if (stopwatch_clear) begin
        stopwatch_factor <= '0;
      end
      if (prog_clear) begin
        prog_timer_factor <= 1'b0;
      end
      if (input_clear) begin
        input_factor <= '0;
      end
    end
  end

endmodule

/* rtl/interrupt_request.sv */
`timescale 1ns/1ps

module interrupt_request (
  input  logic                 clk,
  input  logic                 reset,
  input  irq_pkg::factor_set_t factors,
  input  irq_pkg::mask_set_t   masks,
  output irq_pkg::irq_vec_t    irq_req,
  output logic                 irq_pending,
  output irq_pkg::irq_index_t  irq_index
);
  import irq_pkg::*;

  irq_vec_t   req_next;
  irq_index_t index_next;

  always_comb begin
    req_next = '0;
    req_next[SLOT_CLOCK]      = |(masks.clock & factors.clock);
    req_next[SLOT_STOPWATCH]  = |(masks.stopwatch & factors.stopwatch);
    // K pins were already masked when the factor was set
    req_next[SLOT_K0]         = factors.input_k[0];
    req_next[SLOT_K1]         = factors.input_k[1];
    req_next[SLOT_PROG_TIMER] = masks.prog_timer & factors.prog_timer;
  end

  // Highest pending slot wins, 0 when idle
  always_comb begin
    index_next = '0;
    for (int i = 0; i < IRQ_VEC_W; i++) begin
      if (req_next[i]) begin
        index_next = irq_index_t'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      irq_req     <= '0;
      irq_pending <= 1'b0;
      irq_index   <= '0;
    end else begin
      irq_req     <= req_next;
      irq_pending <= |req_next;
      irq_index   <= index_next;
    end
  end

  // Index points at a set slot with nothing set above it
  a_pending_vec: assert property (
    @(posedge clk) disable iff (reset)
    irq_pending |-> (irq_req != '0) && ((irq_req >> irq_index) == irq_vec_t'(1))
  );

endmodule

/* rtl/irq_axil_regs.sv */
`timescale 1ns/1ps

module irq_axil_regs (
  input  logic                  clk,
  input  logic                  reset,
  // Write address and data
  input  irq_pkg::axil_addr_t   awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  irq_pkg::axil_data_t   wdata,
  input  logic [3:0]            wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  // Write response
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,
  // Read
  input  irq_pkg::axil_addr_t   araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output irq_pkg::axil_data_t   rdata,
  output logic [1:0]            rresp,
  output logic                  rvalid,
  input  logic                  rready,
  // Core side
  input  irq_pkg::factor_set_t  factors,
  input  irq_pkg::step_count_t  step_count,
  output irq_pkg::mask_set_t    masks,
  output irq_pkg::factor_clear_t clears
);
  import irq_pkg::*;

  logic       idle;
  logic       wr_start;
  logic       rd_start;
  logic       wr_fire;
  logic       rd_fire;
  logic [1:0] wr_resp;
  logic [1:0] rd_resp;
  axil_data_t rd_word;

  // One transaction at a time with writes first on a tie
  assign idle     = !awready && !arready && !bvalid && !rvalid;
  assign wr_start = idle && awvalid && wvalid;
  assign rd_start = idle && arvalid && !(awvalid && wvalid);
  assign wr_fire  = awready && awvalid && wready && wvalid;
  assign rd_fire  = arready && arvalid;

  // Only the masks are writable
  always_comb begin
    case (awaddr)
      REG_CLOCK_MASK, REG_STOPWATCH_MASK, REG_PROG_MASK, REG_INPUT_MASK: wr_resp = RESP_OKAY;
      default: wr_resp = RESP_SLVERR;
    endcase
  end

  always_comb begin
    rd_word = '0;
    rd_resp = RESP_OKAY;
    case (araddr)
      REG_CLOCK_MASK:       rd_word = axil_data_t'(masks.clock);
      REG_STOPWATCH_MASK:   rd_word = axil_data_t'(masks.stopwatch);
      REG_PROG_MASK:        rd_word = axil_data_t'(masks.prog_timer);
      REG_INPUT_MASK:       rd_word = axil_data_t'(masks.input_k);
      REG_CLOCK_FACTOR:     rd_word = axil_data_t'(factors.clock);
      REG_STOPWATCH_FACTOR: rd_word = axil_data_t'(factors.stopwatch);
      REG_PROG_FACTOR:      rd_word = axil_data_t'(factors.prog_timer);
      REG_INPUT_FACTOR:     rd_word = axil_data_t'(factors.input_k);
      REG_STEP_COUNT:       rd_word = axil_data_t'(step_count);
      default:              rd_resp = RESP_SLVERR;
    endcase
  end

  // Clear-on-read strobe in the accept cycle
  always_comb begin
    clears = '0;
    if (rd_fire) begin
      case (araddr)
        REG_CLOCK_FACTOR:     clears.clock = 1'b1;
        REG_STOPWATCH_FACTOR: clears.stopwatch = 1'b1;
        REG_PROG_FACTOR:      clears.prog_timer = 1'b1;
        REG_INPUT_FACTOR:     clears.input_k = 1'b1;
        default:              clears = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
      masks   <= '0;
    end else begin
      awready <= wr_start;
      wready  <= wr_start;
      arready <= rd_start;

      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end

      if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end

      if (wr_fire && wstrb[0]) begin
        case (awaddr)
          REG_CLOCK_MASK:     masks.clock <= wdata[3:0];
          REG_STOPWATCH_MASK: masks.stopwatch <= wdata[1:0];
          REG_PROG_MASK:      masks.prog_timer <= wdata[0];
          REG_INPUT_MASK:     masks.input_k <= wdata[1:0];
          default:            masks <= masks;
        endcase
      end
    end
  end

  // Response payload captured with the pre-clear factors
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp <= wr_resp;
    end
    if (rd_fire) begin
      rdata <= rd_word;
      rresp <= rd_resp;
    end
  end

  a_bvalid_hold: assert property (
    @(posedge clk) disable iff (reset)
    (bvalid && !bready) |=> (bvalid && $stable(bresp))
  );

  a_rvalid_hold: assert property (
    @(posedge clk) disable iff (reset)
    (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp))
  );

endmodule

/* rtl/interrupt_top.sv */
`timescale 1ns/1ps

module interrupt_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                clk_en,
  input  logic [1:0]          stopwatch_event,
  input  logic                prog_timer_event,
  input  logic [1:0]          k_pins,
  // AXI4-Lite slave
  input  irq_pkg::axil_addr_t awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  irq_pkg::axil_data_t wdata,
  input  logic [3:0]          wstrb,
  input  logic                wvalid,
  output logic                wready,
  output logic [1:0]          bresp,
  output logic                bvalid,
  input  logic                bready,
  input  irq_pkg::axil_addr_t araddr,
  input  logic                arvalid,
  output logic                arready,
  output irq_pkg::axil_data_t rdata,
  output logic [1:0]          rresp,
  output logic                rvalid,
  input  logic                rready,
  // Interrupt outputs
  output irq_pkg::irq_vec_t   irq_req,
  output logic                irq_pending,
  output irq_pkg::irq_index_t irq_index
);
  import irq_pkg::*;

  timer_levels_t levels;
  step_count_t   step_count;
  logic [3:0]    clock_factor;
  logic [1:0]    stopwatch_factor;
  logic          prog_timer_factor;
  logic [1:0]    input_factor;
  factor_set_t   factors;
  mask_set_t     masks;
  factor_clear_t clears;

  assign factors = '{
    clock:      clock_factor,
    stopwatch:  stopwatch_factor,
    prog_timer: prog_timer_factor,
    input_k:    input_factor
  };

  clock_timebase u_timebase (
    .clk        (clk),
    .reset      (reset),
    .clk_en     (clk_en),
    .levels     (levels),
    .step_count (step_count)
  );

  clock_factor_latch u_clock_latch (
    .clk          (clk),
    .reset        (reset),
    .clk_en       (clk_en),
    .levels       (levels),
    .clear        (clears.clock),
    .clock_factor (clock_factor)
  );

  peripheral_factor_latch u_periph_latch (
    .clk               (clk),
    .reset             (reset),
    .clk_en            (clk_en),
    .stopwatch_event   (stopwatch_event),
    .prog_timer_event  (prog_timer_event),
    .k_pins            (k_pins),
    .input_mask        (masks.input_k),
    .stopwatch_clear   (clears.stopwatch),
    .prog_clear        (clears.prog_timer),
    .input_clear       (clears.input_k),
    .stopwatch_factor  (stopwatch_factor),
    .prog_timer_factor (prog_timer_factor),
    .input_factor      (input_factor)
  );

  interrupt_request u_request (
    .clk         (clk),
    .reset       (reset),
    .factors     (factors),
    .masks       (masks),
    .irq_req     (irq_req),
    .irq_pending (irq_pending),
    .irq_index   (irq_index)
  );

  irq_axil_regs u_regs (
    .clk        (clk),
    .reset      (reset),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .factors    (factors),
    .step_count (step_count),
    .masks      (masks),
    .clears     (clears)
  );

endmodule

/* include/irq_tb_tasks.svh */
`ifndef IRQ_TB_TASKS_SVH
`define IRQ_TB_TASKS_SVH

// Included inside the testbench module
// Drives the AXI4-Lite signals of that scope on the falling edge of clk

task automatic axil_write(
  input  irq_pkg::axil_addr_t addr,
  input  irq_pkg::axil_data_t data,
  output logic [1:0]          resp,
  output bit                  ok,
  input  int                  timeout = 64
);
  int cycles;
  ok      = 1'b1;
  resp    = 2'b00;
  cycles  = 0;
  @(negedge clk);
  awaddr  = addr;
  wdata   = data;
  wstrb   = 4'hF;
  awvalid = 1'b1;
  wvalid  = 1'b1;
  bready  = 1'b1;
  while (!(awready && wready) && cycles < timeout) begin
    @(negedge clk);
    cycles++;
  end
  if (!(awready && wready)) begin
    $display("[ERROR] timeout waiting for awready/wready at 0x%02h", addr);
    ok = 1'b0;
  end
  // Handshake completes on the coming rising edge
  @(negedge clk);
  awvalid = 1'b0;
  wvalid  = 1'b0;
  cycles  = 0;
  while (!bvalid && cycles < timeout) begin
    @(negedge clk);
    cycles++;
  end
  if (!bvalid) begin
    $display("[ERROR] timeout waiting for bvalid at 0x%02h", addr);
    ok = 1'b0;
  end
  resp = bresp;
  @(negedge clk);
  bready = 1'b0;
endtask

// rready stays low for hold cycles while rdata must not move
task automatic axil_read(
  input  irq_pkg::axil_addr_t addr,
  output irq_pkg::axil_data_t data,
  output logic [1:0]          resp,
  output bit                  ok,
  input  int                  hold = 0,
  input  int                  timeout = 64
);
  int cycles;
  ok      = 1'b1;
  data    = '0;
  resp    = 2'b00;
  cycles  = 0;
  @(negedge clk);
  araddr  = addr;
  arvalid = 1'b1;
  rready  = 1'b0;
  while (!arready && cycles < timeout) begin
    @(negedge clk);
    cycles++;
  end
  if (!arready) begin
    $display("[ERROR] timeout waiting for arready at 0x%02h", addr);
    ok = 1'b0;
  end
  @(negedge clk);
  arvalid = 1'b0;
  cycles  = 0;
  while (!rvalid && cycles < timeout) begin
    @(negedge clk);
    cycles++;
  end
  if (!rvalid) begin
    $display("[ERROR] timeout waiting for rvalid at 0x%02h", addr);
    ok = 1'b0;
  end
  data = rdata;
  resp = rresp;
  repeat (hold) begin
    @(negedge clk);
    if (!rvalid || rdata !== data || rresp !== resp) begin
      $display("[ERROR] read data moved under back-pressure at 0x%02h", addr);
      ok = 1'b0;
    end
  end
  rready = 1'b1;
  @(negedge clk);
  rready = 1'b0;
endtask

task automatic check_value(
  input  string       name,
  input  logic [31:0] expected,
  input  logic [31:0] got,
  output bit          ok
);
  ok = (got === expected);
  if (!ok) begin
    $display("[ERROR] %s expected 0x%0h got 0x%0h", name, expected, got);
  end
endtask

`endif

/* test/interrupt_tb.sv */
`timescale 1ns/1ps

module interrupt_tb;
  import irq_pkg::*;

  logic       clk;
  logic       reset;
  logic       clk_en;
  logic [1:0] stopwatch_event;
  logic       prog_timer_event;
  logic [1:0] k_pins;
  axil_addr_t awaddr;
  logic       awvalid;
  logic       awready;
  axil_data_t wdata;
  logic [3:0] wstrb;
  logic       wvalid;
  logic       wready;
  logic [1:0] bresp;
  logic       bvalid;
  logic       bready;
  axil_addr_t araddr;
  logic       arvalid;
  logic       arready;
  axil_data_t rdata;
  logic [1:0] rresp;
  logic       rvalid;
  logic       rready;
  irq_vec_t   irq_req;
  logic       irq_pending;
  irq_index_t irq_index;

  integer seed;

  // Reference model of timebase, latches and request stage
  int          m_div;
  step_count_t m_step;
  logic [3:0]  m_prev_lv;
  logic [3:0]  m_clock;
  logic [1:0]  m_sw;
  logic        m_prog;
  logic [1:0]  m_in;
  logic [1:0]  m_prev_k;
  logic [3:0]  m_mask_clock;
  logic [1:0]  m_mask_sw;
  logic        m_mask_prog;
  logic [1:0]  m_mask_in;
  irq_vec_t    m_req;
  logic        m_pending;
  irq_index_t  m_index;

  // Ready flags seen at the falling edge mark the accept edge
  logic ar_seen;
  logic aw_seen;
  logic w_seen;

  int    test_errors;
  int    tests_passed;
  int    tests_failed;
  int    stray_errors;
  bit    in_test;
  string test_name;

  `include "irq_tb_tasks.svh"

  interrupt_top UUT (
    .clk              (clk),
    .reset            (reset),
    .clk_en           (clk_en),
    .stopwatch_event  (stopwatch_event),
    .prog_timer_event (prog_timer_event),
    .k_pins           (k_pins),
    .awaddr           (awaddr),
    .awvalid          (awvalid),
    .awready          (awready),
    .wdata            (wdata),
    .wstrb            (wstrb),
    .wvalid           (wvalid),
    .wready           (wready),
    .bresp            (bresp),
    .bvalid           (bvalid),
    .bready           (bready),
    .araddr           (araddr),
    .arvalid          (arvalid),
    .arready          (arready),
    .rdata            (rdata),
    .rresp            (rresp),
    .rvalid           (rvalid),
    .rready           (rready),
    .irq_req          (irq_req),
    .irq_pending      (irq_pending),
    .irq_index        (irq_index)
  );

  always #50 clk = ~clk;

  always @(negedge clk) begin
    // Enabled in about three cycles out of four
    clk_en  = ($random(seed) & 3) != 0;
    ar_seen = arready;
    aw_seen = awready;
    w_seen  = wready;
  end

  // Bit 0 is 32 Hz, then 8 Hz, 2 Hz, 1 Hz
  function automatic logic [3:0] levels_of(input step_count_t s);
    return {s[7], s[6], s[4], s[2]};
  endfunction

  function automatic irq_vec_t expected_request();
    irq_vec_t v;
    v     = '0;
    v[1]  = |(m_mask_clock & m_clock);
    v[3]  = |(m_mask_sw & m_sw);
    v[5]  = m_in[0];
    v[7]  = m_in[1];
    v[11] = m_mask_prog & m_prog;
    return v;
  endfunction

  function automatic irq_index_t highest_slot(input irq_vec_t v);
    irq_index_t idx;
    bit         found;
    idx   = '0;
    found = 1'b0;
    for (int i = 14; i >= 0; i--) begin
      if (v[i] && !found) begin
        idx   = irq_index_t'(i);
        found = 1'b1;
      end
    end
    return idx;
  endfunction

  always @(posedge clk) begin : request_model
    logic [3:0] lv;
    logic [1:0] k_fall;
    irq_vec_t   req;
    if (reset) begin
      m_div        = 0;
      m_step       = '0;
      m_prev_lv    = '0;
      m_clock      = '0;
      m_sw         = '0;
      m_prog       = 1'b0;
      m_in         = '0;
      m_prev_k     = '0;
      m_mask_clock = '0;
      m_mask_sw    = '0;
      m_mask_prog  = 1'b0;
      m_mask_in    = '0;
      m_req        = '0;
      m_pending    = 1'b0;
      m_index      = '0;
    end else begin
      // Request outputs lag the factors by one edge
      req       = expected_request();
      m_req     = req;
      m_pending = |req;
      m_index   = highest_slot(req);
      lv        = levels_of(m_step);
      k_fall    = m_prev_k & ~k_pins & m_mask_in;
      if (clk_en) begin
        m_clock   = m_clock | (m_prev_lv & ~lv);
        m_prev_lv = lv;
        m_sw      = m_sw | stopwatch_event;
        m_prog    = m_prog | prog_timer_event;
        m_in      = m_in | k_fall;
        m_prev_k  = k_pins;
        if (m_div == TIMEBASE_DIV - 1) begin
          m_div  = 0;
          m_step = m_step + 1'b1;
        end else begin
          m_div = m_div + 1;
        end
      end
      // Read clear wins over a set on the same edge
      if (ar_seen && arvalid) begin
        case (araddr)
          REG_CLOCK_FACTOR:     m_clock = '0;
          REG_STOPWATCH_FACTOR: m_sw = '0;
          REG_PROG_FACTOR:      m_prog = 1'b0;
          REG_INPUT_FACTOR:     m_in = '0;
          default:              m_clock = m_clock;
        endcase
      end
      if (aw_seen && w_seen && awvalid && wvalid && wstrb[0]) begin
        case (awaddr)
          REG_CLOCK_MASK:     m_mask_clock = wdata[3:0];
          REG_STOPWATCH_MASK: m_mask_sw = wdata[1:0];
          REG_PROG_MASK:      m_mask_prog = wdata[0];
          REG_INPUT_MASK:     m_mask_in = wdata[1:0];
          default:            m_mask_clock = m_mask_clock;
        endcase
      end
    end
  end

  task automatic count_result(input bit ok);
    if (!ok) begin
      test_errors++;
    end
  endtask

  task automatic finish_test();
    if (in_test) begin
      if (test_errors == 0) begin
        $display("test %s: passed", test_name);
        tests_passed++;
      end else begin
        $display("test %s: failed with %0d errors", test_name, test_errors);
        tests_failed++;
      end
    end else begin
      stray_errors += test_errors;
    end
    test_errors = 0;
  endtask

  // Events stay up until one enabled edge has taken them
  task automatic pulse_events(input logic [1:0] sw, input logic prog);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    @(negedge clk);
    stopwatch_event  = sw;
    prog_timer_event = prog;
    while (!seen && cycles < 64) begin
      @(posedge clk);
      seen = clk_en;
      cycles++;
    end
    @(negedge clk);
    stopwatch_event  = '0;
    prog_timer_event = 1'b0;
    if (!seen) begin
      $display("timeout: no enabled cycle while pulsing events");
      test_errors++;
    end
  endtask

  task automatic set_pins(input logic [1:0] pins);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    @(negedge clk);
    k_pins = pins;
    while (!seen && cycles < 64) begin
      @(posedge clk);
      seen = clk_en;
      cycles++;
    end
    @(negedge clk);
    if (!seen) begin
      $display("timeout: K pin level never sampled by an enabled cycle");
      test_errors++;
    end
  endtask

  task automatic wait_for_step(input step_count_t target);
    axil_data_t data;
    logic [1:0] resp;
    bit         ok;
    bit         reached;
    int         polls;
    ok      = 1'b1;
    reached = 1'b0;
    polls   = 0;
    while (!reached && ok && polls < 400) begin
      axil_read(REG_STEP_COUNT, data, resp, ok);
      count_result(ok);
      reached = (data[7:0] >= target);
      polls++;
    end
    if (!reached) begin
      $display("timeout: step count never reached 0x%02h", target);
      test_errors++;
    end
  endtask

  task automatic check_request();
    bit ok;
    @(negedge clk);
    check_value("irq_req", 32'(m_req), 32'(irq_req), ok);
    count_result(ok);
    check_value("irq_pending", 32'(m_pending), 32'(irq_pending), ok);
    count_result(ok);
    check_value("irq_index", 32'(m_index), 32'(irq_index), ok);
    count_result(ok);
  endtask

  task automatic run_line(input string line);
    byte         cmd;
    int          n;
    string       rest;
    string       name;
    logic [31:0] f0;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    axil_data_t  data;
    logic [1:0]  resp;
    bit          ok;
    if (line.len() < 1) begin
      return;
    end
    cmd = line.getc(0);
    if (cmd == "#" || cmd == "\n" || cmd == " " || cmd == "\r") begin
      return;
    end
    rest = line.substr(1, line.len() - 1);
    f0   = '0;
    f1   = '0;
    f2   = '0;
    f3   = '0;
    n    = $sscanf(rest, "%h %h %h %h", f0, f1, f2, f3);
    case (cmd)
      "T": begin
        finish_test();
        n         = $sscanf(rest, "%s", name);
        test_name = name;
        in_test   = 1'b1;
      end
      "W": begin
        axil_write(f0[7:0], f1, resp, ok);
        count_result(ok);
        check_value("bresp", f2, 32'(resp), ok);
        count_result(ok);
      end
      "R": begin
        axil_read(f0[7:0], data, resp, ok, int'(f3));
        count_result(ok);
        check_value("rdata", f1, data, ok);
        count_result(ok);
        check_value("rresp", f2, 32'(resp), ok);
        count_result(ok);
      end
      "E": pulse_events(f0[1:0], f1[0]);
      "K": set_pins(f0[1:0]);
      "S": wait_for_step(f0[7:0]);
      "I": check_request();
      default: begin
        $display("unknown command in data file: %s", line);
        test_errors++;
      end
    endcase
  endtask

  initial begin
    integer fd;
    string  line;
    seed             = 32'h3b20_81e2;
    clk              = 1'b0;
    reset            = 1'b1;
    clk_en           = 1'b0;
    stopwatch_event  = '0;
    prog_timer_event = 1'b0;
    k_pins           = '0;
    awaddr           = '0;
    awvalid          = 1'b0;
    wdata            = '0;
    wstrb            = '0;
    wvalid           = 1'b0;
    bready           = 1'b0;
    araddr           = '0;
    arvalid          = 1'b0;
    rready           = 1'b0;
    test_errors      = 0;
    tests_passed     = 0;
    tests_failed     = 0;
    stray_errors     = 0;
    in_test          = 1'b0;
    test_name        = "";

    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    fd = $fopen("test/interrupt_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open test/interrupt_testdata.txt");
      stray_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0) begin
          run_line(line);
        end
      end
      $fclose(fd);
    end
    finish_test();

    $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0 && stray_errors == 0 && tests_passed > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+include
rtl/irq_pkg.sv
rtl/clock_timebase.sv
rtl/clock_factor_latch.sv
rtl/peripheral_factor_latch.sv
rtl/interrupt_request.sv
rtl/irq_axil_regs.sv
rtl/interrupt_top.sv
test/interrupt_tb.sv

/* test/interrupt_testdata.txt */
# T name | W addr data bresp | R addr rdata rresp hold_cycles | E sw prog | K pins
# S step (wait until reached) | I (check request outputs against model), all hex
T reset_state
R 20 00000000 0 0
R 10 00000000 0 0
R 14 00000000 0 0
R 18 00000000 0 0
R 1C 00000000 0 0
R 00 00000000 0 0
R 04 00000000 0 0
R 08 00000000 0 0
R 0C 00000000 0 0
I
T clock_factor
S 08
R 10 00000001 0 0
R 10 00000000 0 0
W 00 00000001 0
S 10
I
R 10 00000001 0 0
I
W 00 00000000 0
T stopwatch_prog
E 1 0
I
W 04 00000001 0
I
E 0 1
I
W 08 00000001 0
I
R 14 00000001 0 0
R 18 00000001 0 0
I
T k_pins
K 3
K 0
R 1C 00000000 0 0
W 0C 00000003 0
K 3
K 2
I
K 0
I
R 1C 00000003 0 0
I
W 0C 00000001 0
K 3
K 0
R 1C 00000001 0 0
T register_errors
W 00 0000000F 0
W 10 0000000F 2
W 24 00000001 2
W 20 00000055 2
R 24 00000000 2 0
R 00 0000000F 0 0
R 04 00000001 0 0
R 08 00000001 0 0
R 0C 00000001 0 0
I
T back_pressure
E 1 0
R 14 00000001 0 6
I
E 2 0
R 14 00000002 0 0
R 14 00000000 0 0
I
